// ==== all.f ====
hw/soc_cfg_pkg.sv
hw/soc_bus_pkg.sv
hw/sdp_ram.sv
hw/icache_fill.sv
hw/icache.sv
hw/dmem_io_decode.sv
hw/soc_mem_top.sv
dv/soc_mem_properties.sv
dv/soc_mem_tb.sv

// ==== Makefile ====
TOP := soc_mem_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== dv/soc_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_mem_tb;

  localparam int NUM_FETCHES = 300;
  localparam int NUM_STORES  = 300;
  localparam int NUM_IO_OPS  = 60;
  // Memory init, fills under back-pressure and the load/store tests, with margin
  localparam int CYCLE_LIMIT = 20000;

  logic                    clk;
  logic                    rst_n;
  soc_bus_pkg::fetch_req_t fetch_req;
  soc_bus_pkg::fetch_rsp_t fetch_rsp;
  soc_bus_pkg::dmem_req_t  dmem_req;
  logic [31:0]             dmem_rdata;
  soc_bus_pkg::io_req_t    io;
  logic [31:0]             io_rdata = '0;
  soc_bus_pkg::mem_ar_t    ar;
  logic                    ar_ready = 1'b0;
  soc_bus_pkg::mem_r_t     r = '0;
  logic                    r_ready;

  integer seed     = 32'h6fa4;
  integer bus_seed = 32'h6fa4 ^ 32'h0000_5a5a;

  int cycles       = 0;
  int test_errors  = 0;
  int total_errors = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  // External memory model
  logic        mem_busy = 1'b0;
  logic [31:0] mem_base;
  int          mem_beat;
  int          ar_count = 0;
  logic [31:0] last_ar_addr;
  logic [31:0] bus_rnd;

  // I/O device model
  int          io_ren_count = 0;
  int          io_wen_count = 0;
  logic [31:0] io_seen_raddr;
  logic [31:0] io_seen_waddr;
  logic [31:0] io_seen_wdata;
  logic [3:0]  io_seen_wstrb;

  // Reference models
  logic [31:0]  dmem_model [1024];
  logic [19:0]  tag_model [128];
  logic [127:0] line_valid_model;

  soc_mem_top soc_mem_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_rsp  (fetch_rsp),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .io         (io),
    .io_rdata   (io_rdata),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_ready    (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] mem_hash(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e37_79b1;
    return h ^ (h >> 15) ^ 32'h5a17_c3e9;
  endfunction

  function automatic logic [31:0] io_hash(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h85eb_ca6b;
    return h ^ (h >> 13) ^ 32'h3c6e_f372;
  endfunction

  function automatic logic [127:0] beat_data(input logic [31:0] addr);
    logic [127:0] d;
    for (int w = 0; w < 4; w++) begin
      d[w*32 +: 32] = mem_hash(addr + 32'(w * 4));
    end
    return d;
  endfunction

  // Burst memory with random ready and valid gaps
  always @(negedge clk) begin
    bus_rnd  = $random(bus_seed);
    ar_ready = bus_rnd[0] | bus_rnd[1];
    r        = '0;
    if (!rst_n) begin
      mem_busy = 1'b0;
    end else begin
      // r_ready is high exactly while a burst is outstanding
      if (r_ready !== mem_busy) begin
        report_mismatch("r_ready", 32'(r_ready), 32'(mem_busy));
      end
      if (!mem_busy) begin
        if (ar.valid && ar_ready) begin
          mem_busy     = 1'b1;
          mem_base     = ar.addr;
          mem_beat     = 0;
          last_ar_addr = ar.addr;
          ar_count++;
        end
      end else if (r_ready && bus_rnd[2]) begin
        r.valid = 1'b1;
        r.data  = beat_data(mem_base + 32'(mem_beat * 16));
        r.last  = (mem_beat == soc_cfg_pkg::BEATS_PER_LINE - 1);
        if (r.last) begin
          mem_busy = 1'b0;
        end else begin
          mem_beat++;
        end
      end
    end
  end

  // Registered device, read data follows the last read address
  always @(posedge clk) begin
    if (io.ren) begin
      io_rdata      <= io_hash(io.raddr);
      io_seen_raddr <= io.raddr;
      io_ren_count  <= io_ren_count + 1;
    end
    if (io.wen) begin
      io_seen_waddr <= io.waddr;
      io_seen_wdata <= io.wdata;
      io_seen_wstrb <= io.wstrb;
      io_wen_count  <= io_wen_count + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error %s: got %h expected %h", name, got, exp);
    test_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic predict_fetch(input logic [31:0] addr, output logic miss);
    logic [6:0] idx;
    idx  = addr[11:5];
    miss = !line_valid_model[idx] || (tag_model[idx] != addr[31:12]);
    line_valid_model[idx] = 1'b1;
    tag_model[idx] = addr[31:12];
  endtask

  // Holds the request through the stall, returns on the first cycle without it
  task automatic fetch(input logic [31:0] addr, output logic [31:0] word,
                       output logic stalled);
    fetch_req.ren  = 1'b1;
    fetch_req.addr = addr;
    @(negedge clk);
    stalled = fetch_rsp.stall;
    while (fetch_rsp.stall) begin
      @(negedge clk);
    end
    word = fetch_rsp.rdata;
    fetch_req.ren = 1'b0;
  endtask

  task automatic store(input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] strb);
    dmem_req.wen   = 1'b1;
    dmem_req.waddr = addr;
    dmem_req.wdata = data;
    dmem_req.wstrb = strb;
    if (!addr[31]) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          dmem_model[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
        end
      end
    end
    @(negedge clk);
    dmem_req.wen = 1'b0;
  endtask

  task automatic load(input logic [31:0] addr, output logic [31:0] data);
    dmem_req.ren   = 1'b1;
    dmem_req.raddr = addr;
    @(negedge clk);
    data = dmem_rdata;
    dmem_req.ren = 1'b0;
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] word;
    logic [31:0] rnd;
    logic [31:0] op_rnd;
    logic        stalled;
    logic        miss;
    int          ar_before;
    int          misses;
    int          stores;
    int          io_r0;
    int          io_w0;
    int          assert_failures;

    fetch_req        = '0;
    dmem_req         = '0;
    line_valid_model = '0;
    rst_n            = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    if (fetch_rsp.stall !== 1'b0) report_mismatch("fetch_rsp.stall", 32'(fetch_rsp.stall), 0);
    if (ar.valid !== 1'b0) report_mismatch("ar.valid", 32'(ar.valid), 0);
    if (io.ren !== 1'b0) report_mismatch("io.ren", 32'(io.ren), 0);
    if (io.wen !== 1'b0) report_mismatch("io.wen", 32'(io.wen), 0);
    finish_test("reset state");

    ar_before = ar_count;
    addr = 32'h0000_1a44;
    predict_fetch(addr, miss);
    fetch(addr, word, stalled);
    if (!stalled) report_failure("first fetch to a cold line did not stall");
    if (word !== mem_hash(addr)) report_mismatch("fetch_rsp.rdata", word, mem_hash(addr));
    if (ar_count != ar_before + 1) begin
      report_failure($sformatf("cold line fill sent %0d ar requests instead of one",
                               ar_count - ar_before));
    end
    if (last_ar_addr !== {addr[31:5], 5'b0}) begin
      report_mismatch("ar.addr", last_ar_addr, {addr[31:5], 5'b0});
    end
    predict_fetch(addr + 32'h8, miss);
    fetch(addr + 32'h8, word, stalled);
    if (stalled) report_failure("second fetch in a filled line stalled");
    if (word !== mem_hash(addr + 32'h8)) begin
      report_mismatch("fetch_rsp.rdata", word, mem_hash(addr + 32'h8));
    end
    finish_test("cold miss then hit");

    ar_before = ar_count;
    misses = 0;
    for (int i = 0; i < NUM_FETCHES; i++) begin
      rnd  = $random(seed);
      addr = {18'b0, rnd[13:2], 2'b00};
      predict_fetch(addr, miss);
      if (miss) misses++;
      fetch(addr, word, stalled);
      if (stalled != miss) begin
        report_failure($sformatf("fetch at %h stalled=%0b but the tag model predicts miss=%0b",
                                 addr, stalled, miss));
      end
      if (word !== mem_hash(addr)) report_mismatch("fetch_rsp.rdata", word, mem_hash(addr));
    end
    if (ar_count - ar_before != misses) begin
      report_failure($sformatf("saw %0d ar requests but the tag model predicts %0d misses",
                               ar_count - ar_before, misses));
    end
    finish_test("random fetches");

    // Every word gets a known value before the mixed traffic
    for (int w = 0; w < 1024; w++) begin
      data = $random(seed);
      store(32'(w * 4), data, 4'hf);
    end
    io_r0  = io_ren_count;
    io_w0  = io_wen_count;
    stores = 0;
    while (stores < NUM_STORES) begin
      rnd    = $random(seed);
      op_rnd = $random(seed);
      data   = $random(seed);
      addr   = {1'b0, rnd[30:2], 2'b00};
      if (op_rnd[0]) begin
        store(addr, data, op_rnd[7:4]);
        stores++;
      end else begin
        load(addr, word);
        if (word !== dmem_model[addr[11:2]]) begin
          report_mismatch("dmem_rdata", word, dmem_model[addr[11:2]]);
        end
      end
    end
    if (io_ren_count != io_r0 || io_wen_count != io_w0) begin
      report_failure("an io enable rose during data memory accesses");
    end
    finish_test("data memory loads and stores");

    for (int i = 0; i < NUM_IO_OPS; i++) begin
      rnd    = $random(seed);
      op_rnd = $random(seed);
      data   = $random(seed);
      addr   = {1'b1, rnd[30:2], 2'b00};
      if (op_rnd[0]) begin
        io_w0 = io_wen_count;
        store(addr, data, op_rnd[7:4]);
        if (io_wen_count != io_w0 + 1) report_failure("io.wen did not pulse for an I/O store");
        if (io_seen_waddr !== addr) report_mismatch("io.waddr", io_seen_waddr, addr);
        if (io_seen_wdata !== data) report_mismatch("io.wdata", io_seen_wdata, data);
        if (io_seen_wstrb !== op_rnd[7:4]) begin
          report_mismatch("io.wstrb", 32'(io_seen_wstrb), 32'(op_rnd[7:4]));
        end
      end else begin
        io_r0 = io_ren_count;
        load(addr, word);
        if (io_ren_count != io_r0 + 1) report_failure("io.ren did not pulse for an I/O load");
        if (io_seen_raddr !== addr) report_mismatch("io.raddr", io_seen_raddr, addr);
        if (word !== io_hash(addr)) report_mismatch("dmem_rdata", word, io_hash(addr));
      end
      // Same word index with bit 31 clear must be untouched
      load({1'b0, addr[30:0]}, word);
      if (word !== dmem_model[addr[11:2]]) begin
        report_mismatch("dmem_rdata", word, dmem_model[addr[11:2]]);
      end
    end
    finish_test("I/O loads and stores");

    assert_failures = soc_mem_top_i.soc_mem_properties_i.failures;
    $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, assert_failures);
    if (total_errors == 0 && tests_failed == 0 && assert_failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/soc_mem_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_mem_properties (
  input wire logic                    clk,
  input wire logic                    rst_n,
  input wire soc_bus_pkg::fetch_req_t fetch_req,
  input wire soc_bus_pkg::fetch_rsp_t fetch_rsp,
  input wire soc_bus_pkg::dmem_req_t  dmem_req,
  input wire soc_bus_pkg::io_req_t    io,
  input wire soc_bus_pkg::mem_ar_t    ar,
  input wire logic                    ar_ready
);

  int failures = 0;

  // Address channel holds until accepted
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar.valid && !ar_ready |=> ar.valid && $stable(ar.addr))
    else begin
      $error("ar.valid dropped or ar.addr changed before ar_ready");
      failures++;
    end

  // An io enable needs a matching data request with bit 31 set
  io_decode: assert property (@(posedge clk) disable iff (!rst_n)
    (!io.ren || (dmem_req.ren && dmem_req.raddr[soc_cfg_pkg::IO_SEL_BIT])) &&
    (!io.wen || (dmem_req.wen && dmem_req.waddr[soc_cfg_pkg::IO_SEL_BIT])))
    else begin
      $error("io enable high without a data request with address bit 31");
      failures++;
    end

  // Requester keeps the missed fetch in place while stalled
  fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_rsp.stall |-> fetch_req.ren && $stable(fetch_req.addr))
    else begin
      $error("fetch request changed while stall was high");
      failures++;
    end

endmodule

bind soc_mem_top soc_mem_properties soc_mem_properties_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .fetch_req (fetch_req),
  .fetch_rsp (fetch_rsp),
  .dmem_req  (dmem_req),
  .io        (io),
  .ar        (ar),
  .ar_ready  (ar_ready)
);

`default_nettype wire

// ==== hw/soc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top (
  input  wire logic                         clk,
  input  wire logic                         rst_n,

  // Instruction fetch
  input  wire soc_bus_pkg::fetch_req_t      fetch_req,
  output soc_bus_pkg::fetch_rsp_t           fetch_rsp,

  // Loads and stores
  input  wire soc_bus_pkg::dmem_req_t       dmem_req,
  output logic [soc_cfg_pkg::XLEN-1:0]      dmem_rdata,

  // Memory-mapped I/O
  output soc_bus_pkg::io_req_t              io,
  input  wire logic [soc_cfg_pkg::XLEN-1:0] io_rdata,

  // External burst read
  output soc_bus_pkg::mem_ar_t              ar,
  input  wire logic                         ar_ready,
  input  wire soc_bus_pkg::mem_r_t          r,
  output logic                              r_ready
);

  icache icache_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (fetch_req),
    .rsp      (fetch_rsp),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r        (r),
    .r_ready  (r_ready)
  );

  dmem_io_decode dmem_io_decode_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (dmem_req),
    .rdata    (dmem_rdata),
    .io       (io),
    .io_rdata (io_rdata)
  );

endmodule

`default_nettype wire

// ==== hw/dmem_io_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_io_decode (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire soc_bus_pkg::dmem_req_t       req,
  output logic [soc_cfg_pkg::XLEN-1:0]      rdata,
  output soc_bus_pkg::io_req_t              io,
  input  wire logic [soc_cfg_pkg::XLEN-1:0] io_rdata
);

  logic [soc_cfg_pkg::XLEN-1:0] mem [soc_cfg_pkg::DMEM_DEPTH];

  logic                            io_sel_rd;
  logic                            io_sel_wr;
  logic                            bram_ren;
  logic                            bram_wen;
  logic [soc_cfg_pkg::DMEM_AW-1:0] bram_raddr;
  logic [soc_cfg_pkg::DMEM_AW-1:0] bram_waddr;
  logic [soc_cfg_pkg::XLEN-1:0]    bram_rdata;
  logic                            io_sel_rd_q;

  assign io_sel_rd = req.raddr[soc_cfg_pkg::IO_SEL_BIT];
  assign io_sel_wr = req.waddr[soc_cfg_pkg::IO_SEL_BIT];

  assign bram_ren = req.ren && !io_sel_rd;
  assign bram_wen = req.wen && !io_sel_wr;

  // Word addresses
  assign bram_raddr = req.raddr[soc_cfg_pkg::DMEM_AW+1:2];
  assign bram_waddr = req.waddr[soc_cfg_pkg::DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (bram_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          mem[bram_waddr][b*8 +: 8] <= req.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bram_ren) begin
      bram_rdata <= mem[bram_raddr];
    end
  end

  // Remembers which side answers the load in the next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      io_sel_rd_q <= 1'b0;
    end else if (req.ren) begin
      io_sel_rd_q <= io_sel_rd;
    end
  end

  assign rdata = io_sel_rd_q ? io_rdata : bram_rdata;

  assign io.ren   = req.ren && io_sel_rd;
  assign io.raddr = req.raddr;
  assign io.wen   = req.wen && io_sel_wr;
  assign io.waddr = req.waddr;
  assign io.wdata = req.wdata;
  assign io.wstrb = req.wstrb;

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire soc_bus_pkg::fetch_req_t req,
  output soc_bus_pkg::fetch_rsp_t      rsp,
  output soc_bus_pkg::mem_ar_t         ar,
  input  wire logic                    ar_ready,
  input  wire soc_bus_pkg::mem_r_t     r,
  output logic                         r_ready
);

  // Request held for the response cycle
  logic                         req_ren_q;
  logic [soc_cfg_pkg::XLEN-1:0] req_addr_q;

  logic [soc_cfg_pkg::INDEX_BITS-1:0] rd_idx;
  logic [soc_cfg_pkg::INDEX_BITS-1:0] req_idx;
  soc_bus_pkg::tag_t                  req_tag;
  logic [soc_cfg_pkg::XLEN-1:0]       line_addr;

  soc_bus_pkg::tag_t  tag_rd;
  soc_bus_pkg::line_t line_rd;
  soc_bus_pkg::line_t fill_line;

  logic [soc_cfg_pkg::NUM_LINES-1:0] valid_q;
  logic                              filling_q;
  logic                              fill_done;
  logic                              fill_start;
  logic                              hit;
  logic                              miss;

  assign rd_idx  = req.addr[soc_cfg_pkg::OFFSET_BITS +: soc_cfg_pkg::INDEX_BITS];
  assign req_idx = req_addr_q[soc_cfg_pkg::OFFSET_BITS +: soc_cfg_pkg::INDEX_BITS];
  assign req_tag = req_addr_q[soc_cfg_pkg::XLEN-1 -: soc_cfg_pkg::TAG_BITS];

  assign line_addr = {req_addr_q[soc_cfg_pkg::XLEN-1:soc_cfg_pkg::OFFSET_BITS],
                      {soc_cfg_pkg::OFFSET_BITS{1'b0}}};

  sdp_ram #(
    .T     (soc_bus_pkg::tag_t),
    .DEPTH (soc_cfg_pkg::NUM_LINES)
  ) tag_ram_i (
    .clk   (clk),
    .we    (fill_done),
    .waddr (req_idx),
    .wdata (req_tag),
    .re    (req.ren),
    .raddr (rd_idx),
    .rdata (tag_rd)
  );

  sdp_ram #(
    .T     (soc_bus_pkg::line_t),
    .DEPTH (soc_cfg_pkg::NUM_LINES)
  ) line_ram_i (
    .clk   (clk),
    .we    (fill_done),
    .waddr (req_idx),
    .wdata (fill_line),
    .re    (req.ren),
    .raddr (rd_idx),
    .rdata (line_rd)
  );

  icache_fill fill_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (fill_start),
    .line_addr (line_addr),
    .ar        (ar),
    .ar_ready  (ar_ready),
    .r         (r),
    .r_ready   (r_ready),
    .done      (fill_done),
    .line      (fill_line)
  );

  assign hit        = req_ren_q && valid_q[req_idx] && (tag_rd == req_tag);
  assign miss       = req_ren_q && !hit;
  assign fill_start = miss && !filling_q;

  // The fill's done cycle is the first cycle with stall low
  assign rsp.stall = filling_q ? !fill_done : miss;

  always_comb begin
    if (!req_ren_q) begin
      rsp.rdata = soc_cfg_pkg::NOP_INSN;
    end else if (fill_done) begin
      rsp.rdata = fill_line[req_addr_q[soc_cfg_pkg::OFFSET_BITS-1:2]*soc_cfg_pkg::XLEN +:
                            soc_cfg_pkg::XLEN];
    end else begin
      rsp.rdata = line_rd[req_addr_q[soc_cfg_pkg::OFFSET_BITS-1:2]*soc_cfg_pkg::XLEN +:
                          soc_cfg_pkg::XLEN];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_ren_q <= 1'b0;
    end else if (!rsp.stall) begin
      req_ren_q <= req.ren;
    end
  end

  always_ff @(posedge clk) begin
    if (!rsp.stall) begin
      req_addr_q <= req.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      filling_q <= 1'b0;
      valid_q   <= '0;
    end else begin
      if (fill_start) begin
        filling_q <= 1'b1;
      end else if (fill_done) begin
        filling_q <= 1'b0;
      end
      if (fill_done) begin
        valid_q[req_idx] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_fill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_fill (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         start,
  input  wire logic [soc_cfg_pkg::XLEN-1:0] line_addr,
  output soc_bus_pkg::mem_ar_t              ar,
  input  wire logic                         ar_ready,
  input  wire soc_bus_pkg::mem_r_t          r,
  output logic                              r_ready,
  output logic                              done,
  output soc_bus_pkg::line_t                line
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } state_t;

  state_t                                           state_q;
  logic [soc_cfg_pkg::XLEN-1:0]                     addr_q;
  logic [$clog2(soc_cfg_pkg::BEATS_PER_LINE)-1:0]   beat_q;
  soc_bus_pkg::line_t                               line_q;
  logic                                             done_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start) begin
            state_q <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (ar_ready) begin
            state_q <= S_DATA;
            beat_q  <= '0;
          end
        end
        S_DATA: begin
          if (r.valid) begin
            beat_q <= beat_q + 1'b1;
            if (r.last) begin
              state_q <= S_IDLE;
              done_q  <= 1'b1;
            end
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Address is captured only when a fill is accepted
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && start) begin
      addr_q <= line_addr;
    end
  end

  // Beats arrive lowest address first
  always_ff @(posedge clk) begin
    if (state_q == S_DATA && r.valid) begin
      line_q[beat_q*soc_cfg_pkg::BUS_BITS +: soc_cfg_pkg::BUS_BITS] <= r.data;
    end
  end

  assign ar.valid = (state_q == S_ADDR);
  assign ar.addr  = addr_q;
  assign r_ready  = (state_q == S_DATA);
  assign done     = done_q;
  assign line     = line_q;

endmodule

`default_nettype wire

// ==== hw/sdp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter type T     = logic,
  parameter int  DEPTH = 16
) (
  input  wire logic                     clk,
  input  wire logic                     we,
  input  wire logic [$clog2(DEPTH)-1:0] waddr,
  input  wire T                         wdata,
  input  wire logic                     re,
  input  wire logic [$clog2(DEPTH)-1:0] raddr,
  output T                              rdata
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Write-first on a collision so a refilled line is visible next cycle
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= (we && (waddr == raddr)) ? wdata : mem[raddr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

  typedef logic [soc_cfg_pkg::LINE_BYTES*8-1:0] line_t;
  typedef logic [soc_cfg_pkg::TAG_BITS-1:0] tag_t;

  // Fetch port
  typedef struct packed {
    logic                         ren;
    logic [soc_cfg_pkg::XLEN-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [soc_cfg_pkg::XLEN-1:0] rdata;
    logic                         stall;
  } fetch_rsp_t;

  // Load/store port from the core
  typedef struct packed {
    logic                         ren;
    logic [soc_cfg_pkg::XLEN-1:0] raddr;
    logic                         wen;
    logic [soc_cfg_pkg::XLEN-1:0] waddr;
    logic [soc_cfg_pkg::XLEN-1:0] wdata;
    logic [3:0]                   wstrb;
  } dmem_req_t;

  // Same fields, qualified for the memory-mapped I/O device
  typedef struct packed {
    logic                         ren;
    logic [soc_cfg_pkg::XLEN-1:0] raddr;
    logic                         wen;
    logic [soc_cfg_pkg::XLEN-1:0] waddr;
    logic [soc_cfg_pkg::XLEN-1:0] wdata;
    logic [3:0]                   wstrb;
  } io_req_t;

  // External burst read channels
  typedef struct packed {
    logic                         valid;
    logic [soc_cfg_pkg::XLEN-1:0] addr;
  } mem_ar_t;

  typedef struct packed {
    logic                             valid;
    logic [soc_cfg_pkg::BUS_BITS-1:0] data;
    logic                             last;
  } mem_r_t;

endpackage

`default_nettype wire

// ==== hw/soc_cfg_pkg.sv ====
`default_nettype none

package soc_cfg_pkg;

  localparam int XLEN = 32;

  // Instruction cache geometry
  localparam int LINE_BYTES     = 32;
  localparam int CACHE_BYTES    = 4096;
  localparam int BUS_BITS       = 128;
  localparam int BEATS_PER_LINE = (LINE_BYTES * 8) / BUS_BITS;
  localparam int NUM_LINES      = CACHE_BYTES / LINE_BYTES;

  // Fetch address split as tag | index | offset
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int INDEX_BITS  = $clog2(NUM_LINES);
  localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS;

  // On-chip data memory, in words
  localparam int DMEM_DEPTH = 1024;
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

  // Loads and stores with this bit set go to the I/O port
  localparam int IO_SEL_BIT = 31;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;

endpackage

`default_nettype wire
